//--- raster_macros.svh
`ifndef RASTER_MACROS_SVH
`define RASTER_MACROS_SVH

// frame buffer size in pixels
`define RAST_HRES 320
`define RAST_VRES 180

// fraction bits carried by the area reciprocal,
// so recip = floor(2**RAST_RECIP_SHIFT / area)
`define RAST_RECIP_SHIFT 24

`endif

//--- raster_pkg.sv
`include "raster_macros.svh"

package raster_pkg;

  // pixel coordinates, sized by the frame
  typedef logic [$clog2(`RAST_HRES)-1:0] xcoord_t;  // 9 bits
  typedef logic [$clog2(`RAST_VRES)-1:0] ycoord_t;  // 8 bits

  typedef logic [15:0] depth_t;

  // edge function values and steps, wide enough for any point of the frame
  typedef logic signed [20:0] edge_t;

  typedef logic [17:0] area_t;  // doubled area, at most 320*180
  typedef logic [`RAST_RECIP_SHIFT:0] recip_t;  // area of 1 gives 2**24

  typedef logic [$clog2(`RAST_HRES * `RAST_VRES)-1:0] pix_addr_t;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_EDGE,
    ST_NORM,
    ST_DIVIDE,
    ST_HOLD
  } setup_state_t;

  typedef enum logic {
    SC_IDLE,
    SC_SCAN
  } scan_state_t;

endpackage

//--- recip_divider.sv
`include "raster_macros.svh"

module recip_divider import raster_pkg::*; (
  input  logic   clk_in,
  input  logic   rst_in,
  input  logic   start,
  input  area_t  area,
  output logic   busy,
  output recip_t recip
);

  logic [4:0]  bits_left;  // quotient bits still to come after this one
  area_t       rem_q;
  area_t       den_q;
  area_t       cur_rem;
  area_t       cur_den;
  logic [18:0] trial;
  logic        fits;

  // the dividend 2**24 has one set bit, and it is the first one shifted in
  assign cur_rem = start ? '0 : rem_q;
  assign cur_den = start ? area : den_q;
  assign trial   = {cur_rem, start};
  assign fits    = (trial >= {1'b0, cur_den});

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      busy      <= 1'b0;
      bits_left <= '0;
    end else if (start) begin
      busy      <= 1'b1;
      bits_left <= 5'(`RAST_RECIP_SHIFT - 1);
    end else if (busy) begin
      if (bits_left == '0) begin
        busy <= 1'b0;  // last quotient bit is taken on this edge
      end
      bits_left <= bits_left - 1'b1;
    end
  end

  // one restoring step per cycle, msb of the quotient first
  always_ff @(posedge clk_in) begin
    if (start || busy) begin
      rem_q <= fits ? area_t'(trial - {1'b0, cur_den}) : trial[17:0];
      den_q <= cur_den;
      recip <= {recip[`RAST_RECIP_SHIFT-1:0], fits};
    end
  end

endmodule

//--- tri_setup.sv
module tri_setup import raster_pkg::*; (
  input  logic    clk_in,
  input  logic    rst_in,
  input  logic    valid_in,
  output logic    ready_out,
  input  xcoord_t x0,
  input  ycoord_t y0,
  input  depth_t  z0,
  input  xcoord_t x1,
  input  ycoord_t y1,
  input  depth_t  z1,
  input  xcoord_t x2,
  input  ycoord_t y2,
  input  depth_t  z2,
  output logic    setup_valid,
  input  logic    setup_ready,
  output xcoord_t bb_xmin,
  output xcoord_t bb_xmax,
  output ycoord_t bb_ymin,
  output ycoord_t bb_ymax,
  output edge_t   e0_start,
  output edge_t   e1_start,
  output edge_t   e2_start,
  output edge_t   e0_dx,
  output edge_t   e1_dx,
  output edge_t   e2_dx,
  output edge_t   e0_dy,
  output edge_t   e1_dy,
  output edge_t   e2_dy,
  output depth_t  tri_z0,
  output depth_t  tri_z1,
  output depth_t  tri_z2,
  output recip_t  tri_recip
);

  setup_state_t state;
  xcoord_t      xv0, xv1, xv2;
  ycoord_t      yv0, yv1, yv2;
  xcoord_t      xmin_c, xmax_c;
  logic [8:0]   ymin_w, ymax_w;  // y tree runs at x width
  edge_t        area_sum;
  logic         area_neg;
  logic         div_start;
  logic         div_busy;

  // comparison tree, returns {min, max}
  function automatic logic [17:0] min_max3(input logic [8:0] a, input logic [8:0] b,
                                           input logic [8:0] c);
    logic [8:0] lo;
    logic [8:0] hi;
    if (a < b) begin
      lo = (a < c) ? a : c;
      hi = (b > c) ? b : c;
    end else begin
      lo = (b < c) ? b : c;
      hi = (a > c) ? a : c;
    end
    return {lo, hi};
  endfunction

  // edge a->b evaluated at point p
  function automatic edge_t edge_at(input xcoord_t xa, input ycoord_t ya, input xcoord_t xb,
                                    input ycoord_t yb, input xcoord_t px, input ycoord_t py);
    return (edge_t'(xb) - edge_t'(xa)) * (edge_t'(py) - edge_t'(ya))
         - (edge_t'(yb) - edge_t'(ya)) * (edge_t'(px) - edge_t'(xa));
  endfunction

  assign {xmin_c, xmax_c} = min_max3(xv0, xv1, xv2);
  assign {ymin_w, ymax_w} = min_max3({1'b0, yv0}, {1'b0, yv1}, {1'b0, yv2});

  assign area_sum    = e0_start + e1_start + e2_start;  // same at every point
  assign area_neg    = area_sum[20];
  assign div_start   = (state == ST_NORM) && (area_sum != '0);
  assign ready_out   = (state == ST_IDLE);
  assign setup_valid = (state == ST_HOLD);

  recip_divider i_recip_divider (
    .clk_in (clk_in),
    .rst_in (rst_in),
    .start  (div_start),
    .area   (area_t'(area_neg ? -area_sum : area_sum)),
    .busy   (div_busy),
    .recip  (tri_recip)
  );

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      state <= ST_IDLE;
    end else begin
      case (state)
        ST_IDLE: begin
          if (valid_in) begin
            state <= ST_EDGE;
          end
        end
        ST_EDGE: state <= ST_NORM;
        ST_NORM: state <= (area_sum == '0) ? ST_IDLE : ST_DIVIDE;  // cull degenerate
        ST_DIVIDE: begin
          if (!div_busy) begin
            state <= ST_HOLD;
          end
        end
        ST_HOLD: begin
          if (setup_ready) begin
            state <= ST_IDLE;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_in) begin
    case (state)
      ST_IDLE: begin
        if (valid_in) begin
          xv0    <= x0;
          yv0    <= y0;
          xv1    <= x1;
          yv1    <= y1;
          xv2    <= x2;
          yv2    <= y2;
          tri_z0 <= z0;
          tri_z1 <= z1;
          tri_z2 <= z2;
        end
      end
      ST_EDGE: begin
        bb_xmin  <= xmin_c;
        bb_xmax  <= xmax_c;
        bb_ymin  <= ymin_w[7:0];
        bb_ymax  <= ymax_w[7:0];
        // edge i lies opposite vertex i
        e0_start <= edge_at(xv1, yv1, xv2, yv2, xmin_c, ymin_w[7:0]);
        e1_start <= edge_at(xv2, yv2, xv0, yv0, xmin_c, ymin_w[7:0]);
        e2_start <= edge_at(xv0, yv0, xv1, yv1, xmin_c, ymin_w[7:0]);
        e0_dx    <= edge_t'(yv1) - edge_t'(yv2);
        e1_dx    <= edge_t'(yv2) - edge_t'(yv0);
        e2_dx    <= edge_t'(yv0) - edge_t'(yv1);
        e0_dy    <= edge_t'(xv2) - edge_t'(xv1);
        e1_dy    <= edge_t'(xv0) - edge_t'(xv2);
        e2_dy    <= edge_t'(xv1) - edge_t'(xv0);
      end
      ST_NORM: begin
        if (area_neg) begin  // flip winding so inside means all >= 0
          e0_start <= -e0_start;
          e1_start <= -e1_start;
          e2_start <= -e2_start;
          e0_dx    <= -e0_dx;
          e1_dx    <= -e1_dx;
          e2_dx    <= -e2_dx;
          e0_dy    <= -e0_dy;
          e1_dy    <= -e1_dy;
          e2_dy    <= -e2_dy;
        end
      end
      default: ;
    endcase
  end

endmodule

//--- pixel_scanner.sv
module pixel_scanner import raster_pkg::*; (
  input  logic    clk_in,
  input  logic    rst_in,
  input  logic    setup_valid,
  output logic    setup_ready,
  input  xcoord_t bb_xmin,
  input  xcoord_t bb_xmax,
  input  ycoord_t bb_ymin,
  input  ycoord_t bb_ymax,
  input  edge_t   e0_start,
  input  edge_t   e1_start,
  input  edge_t   e2_start,
  input  edge_t   e0_dx,
  input  edge_t   e1_dx,
  input  edge_t   e2_dx,
  input  edge_t   e0_dy,
  input  edge_t   e1_dy,
  input  edge_t   e2_dy,
  input  depth_t  tri_z0,
  input  depth_t  tri_z1,
  input  depth_t  tri_z2,
  input  recip_t  tri_recip,
  output logic    scan_valid,
  input  logic    scan_ready,
  output xcoord_t px,
  output ycoord_t py,
  output edge_t   w0,
  output edge_t   w1,
  output edge_t   w2,
  output depth_t  z0,
  output depth_t  z1,
  output depth_t  z2,
  output recip_t  recip
);

  scan_state_t state;
  xcoord_t     xmin;
  xcoord_t     xmax;
  ycoord_t     ymax;
  edge_t       dx0, dx1, dx2;
  edge_t       dy0, dy1, dy2;
  edge_t       row0, row1, row2;  // edge values at the left end of the row
  logic        accept;
  logic        covered;
  logic        stall;
  logic        row_end;
  logic        last_pos;

  assign setup_ready = (state == SC_IDLE);
  assign accept      = setup_valid && setup_ready;
  assign covered     = (w0 >= 0) && (w1 >= 0) && (w2 >= 0);
  assign scan_valid  = (state == SC_SCAN) && covered;
  assign stall       = scan_valid && !scan_ready;  // hold position and edge values
  assign row_end     = (px == xmax);
  assign last_pos    = row_end && (py == ymax);

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      state <= SC_IDLE;
    end else begin
      case (state)
        SC_IDLE: begin
          if (accept) begin
            state <= SC_SCAN;
          end
        end
        SC_SCAN: begin
          if (!stall && last_pos) begin
            state <= SC_IDLE;
          end
        end
        default: state <= SC_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_in) begin
    if (accept) begin
      xmin  <= bb_xmin;
      xmax  <= bb_xmax;
      ymax  <= bb_ymax;
      dx0   <= e0_dx;
      dx1   <= e1_dx;
      dx2   <= e2_dx;
      dy0   <= e0_dy;
      dy1   <= e1_dy;
      dy2   <= e2_dy;
      px    <= bb_xmin;
      py    <= bb_ymin;
      w0    <= e0_start;
      w1    <= e1_start;
      w2    <= e2_start;
      row0  <= e0_start;
      row1  <= e1_start;
      row2  <= e2_start;
      z0    <= tri_z0;
      z1    <= tri_z1;
      z2    <= tri_z2;
      recip <= tri_recip;
    end else if ((state == SC_SCAN) && !stall) begin
      if (row_end) begin
        // wrap to the next row, edges restart from the row-start values
        px   <= xmin;
        py   <= py + 1'b1;
        row0 <= row0 + dy0;
        row1 <= row1 + dy1;
        row2 <= row2 + dy2;
        w0   <= row0 + dy0;
        w1   <= row1 + dy1;
        w2   <= row2 + dy2;
      end else begin
        px <= px + 1'b1;
        w0 <= w0 + dx0;
        w1 <= w1 + dx1;
        w2 <= w2 + dx2;
      end
    end
  end

endmodule

//--- fragment_interp.sv
`include "raster_macros.svh"

module fragment_interp import raster_pkg::*; (
  input  logic      clk_in,
  input  logic      rst_in,
  input  logic      scan_valid,
  output logic      scan_ready,
  input  xcoord_t   px,
  input  ycoord_t   py,
  input  edge_t     w0,
  input  edge_t     w1,
  input  edge_t     w2,
  input  depth_t    z0,
  input  depth_t    z1,
  input  depth_t    z2,
  input  recip_t    recip,
  output logic      valid_out,
  input  logic      ready_in,
  output xcoord_t   x_out,
  output ycoord_t   y_out,
  output depth_t    z_out,
  output pix_addr_t addr_out
);

  logic        adv1, adv2, adv3;
  logic        s1_valid;
  xcoord_t     s1_x;
  ycoord_t     s1_y;
  logic [33:0] s1_p0, s1_p1, s1_p2;  // weight times depth
  recip_t      s1_recip;
  logic        s2_valid;
  xcoord_t     s2_x;
  ycoord_t     s2_y;
  logic [35:0] s2_sum;
  pix_addr_t   s2_row;  // y * 320
  recip_t      s2_recip;
  logic [60:0] z_full;

  // a stage moves when its own output slot is free or being taken
  assign adv3       = !valid_out || ready_in;
  assign adv2       = !s2_valid || adv3;
  assign adv1       = !s1_valid || adv2;
  assign scan_ready = adv1;

  assign z_full = s2_sum * s2_recip;

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      s1_valid  <= 1'b0;
      s2_valid  <= 1'b0;
      valid_out <= 1'b0;
    end else begin
      if (adv1) begin
        s1_valid <= scan_valid;
      end
      if (adv2) begin
        s2_valid <= s1_valid;
      end
      if (adv3) begin
        valid_out <= s2_valid;
      end
    end
  end

  always_ff @(posedge clk_in) begin
    if (adv1 && scan_valid) begin
      s1_x     <= px;
      s1_y     <= py;
      // covered weights are never negative and never exceed the area
      s1_p0    <= area_t'(w0) * z0;
      s1_p1    <= area_t'(w1) * z1;
      s1_p2    <= area_t'(w2) * z2;
      s1_recip <= recip;
    end
    if (adv2 && s1_valid) begin
      s2_x     <= s1_x;
      s2_y     <= s1_y;
      s2_sum   <= s1_p0 + s1_p1 + s1_p2;
      s2_row   <= (pix_addr_t'(s1_y) << 8) + (pix_addr_t'(s1_y) << 6);  // 320 = 256 + 64
      s2_recip <= s1_recip;
    end
    if (adv3 && s2_valid) begin
      x_out    <= s2_x;
      y_out    <= s2_y;
      z_out    <= depth_t'(z_full >> `RAST_RECIP_SHIFT);
      addr_out <= s2_row + pix_addr_t'(s2_x);
    end
  end

endmodule

//--- rasterizer.sv
module rasterizer import raster_pkg::*; (
  input  logic      clk_in,
  input  logic      rst_in,
  input  logic      valid_in,
  output logic      ready_out,
  input  xcoord_t   x0,
  input  ycoord_t   y0,
  input  depth_t    z0,
  input  xcoord_t   x1,
  input  ycoord_t   y1,
  input  depth_t    z1,
  input  xcoord_t   x2,
  input  ycoord_t   y2,
  input  depth_t    z2,
  output logic      valid_out,
  input  logic      ready_in,
  output xcoord_t   x_out,
  output ycoord_t   y_out,
  output depth_t    z_out,
  output pix_addr_t addr_out
);

  // setup to scanner
  logic    setup_valid;
  logic    setup_ready;
  xcoord_t bb_xmin, bb_xmax;
  ycoord_t bb_ymin, bb_ymax;
  edge_t   e0_start, e1_start, e2_start;
  edge_t   e0_dx, e1_dx, e2_dx;
  edge_t   e0_dy, e1_dy, e2_dy;
  depth_t  tri_z0, tri_z1, tri_z2;
  recip_t  tri_recip;

  // scanner to interpolator
  logic    scan_valid;
  logic    scan_ready;
  xcoord_t px;
  ycoord_t py;
  edge_t   w0, w1, w2;
  depth_t  sz0, sz1, sz2;
  recip_t  recip;

  tri_setup i_tri_setup (
    .clk_in      (clk_in),
    .rst_in      (rst_in),
    .valid_in    (valid_in),
    .ready_out   (ready_out),
    .x0          (x0),
    .y0          (y0),
    .z0          (z0),
    .x1          (x1),
    .y1          (y1),
    .z1          (z1),
    .x2          (x2),
    .y2          (y2),
    .z2          (z2),
    .setup_valid (setup_valid),
    .setup_ready (setup_ready),
    .bb_xmin     (bb_xmin),
    .bb_xmax     (bb_xmax),
    .bb_ymin     (bb_ymin),
    .bb_ymax     (bb_ymax),
    .e0_start    (e0_start),
    .e1_start    (e1_start),
    .e2_start    (e2_start),
    .e0_dx       (e0_dx),
    .e1_dx       (e1_dx),
    .e2_dx       (e2_dx),
    .e0_dy       (e0_dy),
    .e1_dy       (e1_dy),
    .e2_dy       (e2_dy),
    .tri_z0      (tri_z0),
    .tri_z1      (tri_z1),
    .tri_z2      (tri_z2),
    .tri_recip   (tri_recip)
  );

  pixel_scanner i_pixel_scanner (
    .clk_in      (clk_in),
    .rst_in      (rst_in),
    .setup_valid (setup_valid),
    .setup_ready (setup_ready),
    .bb_xmin     (bb_xmin),
    .bb_xmax     (bb_xmax),
    .bb_ymin     (bb_ymin),
    .bb_ymax     (bb_ymax),
    .e0_start    (e0_start),
    .e1_start    (e1_start),
    .e2_start    (e2_start),
    .e0_dx       (e0_dx),
    .e1_dx       (e1_dx),
    .e2_dx       (e2_dx),
    .e0_dy       (e0_dy),
    .e1_dy       (e1_dy),
    .e2_dy       (e2_dy),
    .tri_z0      (tri_z0),
    .tri_z1      (tri_z1),
    .tri_z2      (tri_z2),
    .tri_recip   (tri_recip),
    .scan_valid  (scan_valid),
    .scan_ready  (scan_ready),
    .px          (px),
    .py          (py),
    .w0          (w0),
    .w1          (w1),
    .w2          (w2),
    .z0          (sz0),
    .z1          (sz1),
    .z2          (sz2),
    .recip       (recip)
  );

  fragment_interp i_fragment_interp (
    .clk_in     (clk_in),
    .rst_in     (rst_in),
    .scan_valid (scan_valid),
    .scan_ready (scan_ready),
    .px         (px),
    .py         (py),
    .w0         (w0),
    .w1         (w1),
    .w2         (w2),
    .z0         (sz0),
    .z1         (sz1),
    .z2         (sz2),
    .recip      (recip),
    .valid_out  (valid_out),
    .ready_in   (ready_in),
    .x_out      (x_out),
    .y_out      (y_out),
    .z_out      (z_out),
    .addr_out   (addr_out)
  );

endmodule

//--- rasterizer_sva.sv
module rasterizer_sva import raster_pkg::*; (
  input logic      clk_in,
  input logic      rst_in,
  input logic      valid_in,
  input logic      ready_out,
  input xcoord_t   x0,
  input ycoord_t   y0,
  input depth_t    z0,
  input xcoord_t   x1,
  input ycoord_t   y1,
  input depth_t    z1,
  input xcoord_t   x2,
  input ycoord_t   y2,
  input depth_t    z2,
  input logic      valid_out,
  input logic      ready_in,
  input xcoord_t   x_out,
  input ycoord_t   y_out,
  input depth_t    z_out,
  input pix_addr_t addr_out
);

  timeunit 1ns;
  timeprecision 1ps;

  int unsigned error_count = 0;  // failed assertions so far

  // source side keeps the triangle until it is taken
  a_tri_held: assert property (@(posedge clk_in) disable iff (rst_in)
    valid_in && !ready_out |=> valid_in && $stable({x0, y0, z0, x1, y1, z1, x2, y2, z2}))
    else begin
      error_count++;
      $error("triangle inputs changed while ready_out was low");
    end

  a_frag_held: assert property (@(posedge clk_in) disable iff (rst_in)
    valid_out && !ready_in |=> valid_out && $stable({x_out, y_out, z_out, addr_out}))
    else begin
      error_count++;
      $error("fragment outputs changed while ready_in was low");
    end

  a_known: assert property (@(posedge clk_in) disable iff (rst_in)
    !$isunknown({valid_out, ready_out}))
    else begin
      error_count++;
      $error("valid_out or ready_out unknown after reset");
    end

endmodule

bind rasterizer rasterizer_sva i_rasterizer_sva (.*);

//--- tb_rasterizer.sv
`include "raster_macros.svh"

module tb_rasterizer import raster_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  logic      clk_in = 1'b0;
  logic      rst_in = 1'b1;
  logic      valid_in = 1'b0;
  logic      ready_out;
  xcoord_t   x0 = '0, x1 = '0, x2 = '0;
  ycoord_t   y0 = '0, y1 = '0, y2 = '0;
  depth_t    z0 = '0, z1 = '0, z2 = '0;
  logic      valid_out;
  logic      ready_in = 1'b1;
  xcoord_t   x_out;
  ycoord_t   y_out;
  depth_t    z_out;
  pix_addr_t addr_out;

  logic        random_ready = 1'b0;  // back-pressure on the output
  int          seed = 32'hc10b_068b;
  logic [31:0] rnd;
  int          max_addr = 0;
  int          exp_x[$], exp_y[$], exp_z[$], exp_a[$];

  // x0 y0 z0  x1 y1 z1  x2 y2 z2
  int tri_tab [7][9] = '{
    '{10, 10, 1000, 30, 14, 20000, 16, 28, 40000},
    '{10, 10, 1000, 16, 28, 40000, 30, 14, 20000},  // same triangle, other winding
    '{5, 5, 100, 50, 50, 200, 95, 95, 300},         // collinear
    '{40, 20, 5000, 120, 60, 60000, 60, 110, 30000},
    '{0, 0, 0, 319, 179, 65535, 0, 179, 30000},     // touches both frame corners
    '{200, 30, 1234, 250, 40, 4321, 210, 90, 9999},
    '{150, 100, 7777, 170, 150, 500, 100, 120, 65000}
  };
  int send_list [7] = '{0, 1, 2, 3, 5, 4, 6};  // triangles in the order they are sent

  rasterizer i_dut (.*);

  always #10 clk_in = ~clk_in;

  always @(posedge clk_in) begin
    if (random_ready) begin
      rnd = $random(seed);
      ready_in <= rnd[0];
    end else begin
      ready_in <= 1'b1;
    end
  end

  function automatic int min3(input int a, input int b, input int c);
    return (a < b) ? ((a < c) ? a : c) : ((b < c) ? b : c);
  endfunction

  function automatic int max3(input int a, input int b, input int c);
    return (a > b) ? ((a > c) ? a : c) : ((b > c) ? b : c);
  endfunction

  function automatic int box_area(input int idx);
    int w;
    int h;
    w = max3(tri_tab[idx][0], tri_tab[idx][3], tri_tab[idx][6])
      - min3(tri_tab[idx][0], tri_tab[idx][3], tri_tab[idx][6]) + 1;
    h = max3(tri_tab[idx][1], tri_tab[idx][4], tri_tab[idx][7])
      - min3(tri_tab[idx][1], tri_tab[idx][4], tri_tab[idx][7]) + 1;
    return w * h;
  endfunction

  // nothing accepted, nothing in flight
  function automatic logic dut_idle();
    return ready_out && !valid_in && i_dut.setup_ready && !valid_out
        && !i_dut.i_fragment_interp.s1_valid && !i_dut.i_fragment_interp.s2_valid;
  endfunction

  task automatic abort_run();
    $display("Checks failed");
    $fatal(1, "stopping at the first failed check");
  endtask

  task automatic check_field(input string name, input string field, input int expected,
                             input int actual);
    assert (expected == actual) else begin
      $display("** Error %s %s expected %0d actual %0d", name, field, expected, actual);
      abort_run();
    end
  endtask

  // row-major walk of the box with the sign-normalised edge test
  task automatic build_ref(input int idx);
    int     v[9];
    longint area;
    longint recip;
    longint w0, w1, w2;
    longint sum;
    foreach (v[k]) begin
      v[k] = tri_tab[idx][k];
    end
    area = (v[3] - v[0]) * (v[7] - v[1]) - (v[4] - v[1]) * (v[6] - v[0]);
    if (area != 0) begin
      recip = (longint'(1) << `RAST_RECIP_SHIFT) / ((area < 0) ? -area : area);
      for (int y = min3(v[1], v[4], v[7]); y <= max3(v[1], v[4], v[7]); y++) begin
        for (int x = min3(v[0], v[3], v[6]); x <= max3(v[0], v[3], v[6]); x++) begin
          w0 = (v[6] - v[3]) * (y - v[4]) - (v[7] - v[4]) * (x - v[3]);  // edge v1 -> v2
          w1 = (v[0] - v[6]) * (y - v[7]) - (v[1] - v[7]) * (x - v[6]);
          w2 = (v[3] - v[0]) * (y - v[1]) - (v[4] - v[1]) * (x - v[0]);
          if (area < 0) begin
            w0 = -w0;
            w1 = -w1;
            w2 = -w2;
          end
          if (w0 >= 0 && w1 >= 0 && w2 >= 0) begin
            sum = w0 * v[2] + w1 * v[5] + w2 * v[8];
            exp_x.push_back(x);
            exp_y.push_back(y);
            exp_z.push_back(int'(((sum * recip) >> `RAST_RECIP_SHIFT) & 'hffff));
            exp_a.push_back(y * `RAST_HRES + x);
          end
        end
      end
    end
  endtask

  task automatic send_tri(input int idx);
    @(posedge clk_in);
    valid_in <= 1'b1;
    x0 <= xcoord_t'(tri_tab[idx][0]);
    y0 <= ycoord_t'(tri_tab[idx][1]);
    z0 <= depth_t'(tri_tab[idx][2]);
    x1 <= xcoord_t'(tri_tab[idx][3]);
    y1 <= ycoord_t'(tri_tab[idx][4]);
    z1 <= depth_t'(tri_tab[idx][5]);
    x2 <= xcoord_t'(tri_tab[idx][6]);
    y2 <= ycoord_t'(tri_tab[idx][7]);
    z2 <= depth_t'(tri_tab[idx][8]);
    @(posedge clk_in);
    while (!ready_out) begin
      @(posedge clk_in);
    end
    valid_in <= 1'b0;
  endtask

  task automatic expect_frags(input string name);
    logic done;
    done = 1'b0;
    while (!done) begin
      @(posedge clk_in);
      if (valid_out && ready_in) begin
        assert (exp_x.size() > 0) else begin
          $display("%s: DUT sent a fragment that the model does not expect", name);
          abort_run();
        end
        check_field(name, "x_out", exp_x.pop_front(), x_out);
        check_field(name, "y_out", exp_y.pop_front(), y_out);
        check_field(name, "z_out", exp_z.pop_front(), z_out);
        check_field(name, "addr_out", exp_a.pop_front(), addr_out);
        if (addr_out > max_addr) begin
          max_addr = addr_out;
        end
      end else if (dut_idle()) begin
        assert (exp_x.size() == 0) else begin
          $display("%s: DUT went idle with %0d fragments missing", name, exp_x.size());
          abort_run();
        end
        done = 1'b1;
      end
    end
  endtask

  task automatic run_tri(input string name, input int idx);
    build_ref(idx);
    send_tri(idx);
    expect_frags(name);
  endtask

  task automatic test_ccw();
    run_tri("ccw_small", 0);
  endtask

  task automatic test_cw();
    run_tri("cw_small", 1);
  endtask

  task automatic test_degenerate();
    build_ref(2);
    send_tri(2);
    // setup is back in IDLE two cycles after the accepting edge
    repeat (3) @(posedge clk_in);
    assert (ready_out) else begin
      $display("collinear: ready_out was not high again two cycles after the triangle");
      abort_run();
    end
    expect_frags("collinear");
  endtask

  task automatic test_backpressure();
    @(posedge clk_in);
    random_ready <= 1'b1;
    run_tri("backpressure", 3);
    @(posedge clk_in);
    random_ready <= 1'b0;
  endtask

  task automatic test_back_to_back();
    max_addr = 0;
    build_ref(5);
    build_ref(4);
    build_ref(6);
    fork
      begin
        send_tri(5);
        send_tri(4);
        send_tri(6);
      end
      begin
        @(posedge clk_in);  // first triangle is on valid_in from here
        expect_frags("back_to_back");
      end
    join
    check_field("back_to_back", "highest addr_out", `RAST_HRES * `RAST_VRES - 1, max_addr);
  endtask

  initial begin
    repeat (16) @(posedge clk_in);
    rst_in <= 1'b0;
    test_ccw();
    test_cw();
    test_degenerate();
    test_backpressure();
    test_back_to_back();
    if (i_dut.i_rasterizer_sva.error_count == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

  // box positions plus setup overhead for every triangle, with a factor two of slack
  initial begin
    int limit;
    limit = 0;
    foreach (send_list[i]) begin
      limit += box_area(send_list[i]) + 40;
    end
    limit = 2 * limit + 16;
    #(limit * 20);
    $display("Checks failed");
    $fatal(1, "watchdog expired after %0d cycles, the DUT stopped making progress", limit);
  end

endmodule

//--- files.f
+incdir+.
raster_pkg.sv
recip_divider.sv
tri_setup.sv
pixel_scanner.sv
fragment_interp.sv
rasterizer.sv
rasterizer_sva.sv
tb_rasterizer.sv

//--- Bender.yml
package:
  name: rasterizer

sources:
  - include_dirs:
      - .
    files:
      - raster_pkg.sv
      - recip_divider.sv
      - tri_setup.sv
      - pixel_scanner.sv
      - fragment_interp.sv
      - rasterizer.sv
  - target: test
    include_dirs:
      - .
    files:
      - rasterizer_sva.sv
      - tb_rasterizer.sv
